// ==== verilog/mips_settings.svh ====
/* mips core settings
   data width, register file size and fetch parameters */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// data path and address width
`define MIPS_DATA_W   32

// general purpose registers
`define MIPS_REG_NUM  32
`define MIPS_REG_AW   5

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

// byte step between instruction words
`define MIPS_PC_STEP  32'd4

`endif

// ==== verilog/mips_isa_pkg.sv ====
/* mips32 instruction set
   opcodes, function codes and instruction field layouts */
`default_nettype none
`include "mips_settings.svh"

package mips_isa_pkg;

    typedef logic [`MIPS_DATA_W-1:0] word_t;
    typedef logic [`MIPS_REG_AW-1:0] reg_addr_t;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_addiu   = 6'h09,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // special function codes
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef struct packed {
        opcode_e    opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        funct_e     funct;
    } instr_r_t;

    typedef struct packed {
        opcode_e     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } instr_i_t;

    // sll r0, r0, 0
    localparam word_t nop_instr = '0;

endpackage

`default_nettype wire

// ==== verilog/mips_pipe_pkg.sv ====
/* pipeline payloads
   alu operations and the registers between the stages */
`default_nettype none

package mips_pipe_pkg;
    import mips_isa_pkg::*;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_lui
    } alu_op_e;

    // decode to execute
    typedef struct packed {
        alu_op_e   alu_op;
        word_t     op_a;
        word_t     op_b;
        word_t     st_data;
        reg_addr_t wr_addr;
        logic      wr_en;
        logic      is_load;
        logic      is_store;
    } id_ex_t;

    // execute to memory, result doubles as the ram address
    typedef struct packed {
        word_t     result;
        word_t     st_data;
        reg_addr_t wr_addr;
        logic      wr_en;
        logic      is_load;
        logic      is_store;
    } ex_mem_t;

    typedef struct packed {
        logic      wr_en;
        reg_addr_t wr_addr;
        word_t     wr_data;
    } wb_t;

endpackage

`default_nettype wire

// ==== verilog/bypass_if.sv ====
/* forwarding path from a later stage back to decode */
`timescale 1ns/1ps
`default_nettype none

interface bypass_if import mips_isa_pkg::*; ();

    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;
    // result not ready yet, decode must wait
    logic      is_load;

    modport source (output wr_en, output wr_addr, output wr_data, output is_load);
    modport sink (input wr_en, input wr_addr, input wr_data, input is_load);

endinterface

`default_nettype wire

// ==== verilog/fetch.sv ====
/* instruction fetch
   program counter and fetch/decode instruction register */
`timescale 1ns/1ps
`default_nettype none
`include "mips_settings.svh"

module fetch import mips_isa_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    input  logic  stall_i,
    input  word_t rom_data_i,
    output word_t rom_addr_o,
    output logic  rom_en_o,
    output word_t instr_o
);

    word_t pc_q;
    logic  advance;

    // rom is idle in the first edge after reset, nothing to take yet
    assign advance    = rom_en_o && !stall_i;
    assign rom_addr_o = pc_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rom_en_o <= 1'b0;
            pc_q     <= `MIPS_RESET_PC;
            instr_o  <= nop_instr;
        end else begin
            rom_en_o <= 1'b1;
            if (advance) begin
                pc_q    <= pc_q + `MIPS_PC_STEP;
                instr_o <= rom_data_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
/* general purpose register file
   two read ports, one write port passed through to the readers */
`timescale 1ns/1ps
`default_nettype none
`include "mips_settings.svh"

module regfile import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  reg_addr_t rs_addr_i,
    input  reg_addr_t rt_addr_i,
    input  wb_t       wb_i,
    output word_t     rs_data_o,
    output word_t     rt_data_o
);

    word_t regs [`MIPS_REG_NUM];

    // r0 reads zero, a same-cycle write wins over the stored value
    function automatic word_t read_port(input reg_addr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (wb_i.wr_en && wb_i.wr_addr == addr) begin
            val = wb_i.wr_data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rs_data_o = read_port(rs_addr_i);
        rt_data_o = read_port(rt_addr_i);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `MIPS_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wr_en && wb_i.wr_addr != '0) begin
            regs[wb_i.wr_addr] <= wb_i.wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/decode.sv ====
/* instruction decode
   field split, operand forwarding, load-use stall, decode/execute register */
`timescale 1ns/1ps
`default_nettype none

module decode import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  word_t     instr_i,
    input  word_t     rs_data_i,
    input  word_t     rt_data_i,
    bypass_if.sink    ex_byp,
    bypass_if.sink    mem_byp,
    output reg_addr_t rs_addr_o,
    output reg_addr_t rt_addr_o,
    output logic      stall_o,
    output id_ex_t    id_ex_o
);

    instr_r_t r_fmt;
    instr_i_t i_fmt;
    word_t    imm_sext;
    word_t    imm_zext;
    word_t    rs_val;
    word_t    rt_val;
    logic     ex_hit_rs;
    logic     ex_hit_rt;
    logic     mem_hit_rs;
    logic     mem_hit_rt;
    logic     uses_rs;
    logic     uses_rt;
    id_ex_t   dec;

    assign r_fmt     = instr_r_t'(instr_i);
    assign i_fmt     = instr_i_t'(instr_i);
    assign rs_addr_o = r_fmt.rs;
    assign rt_addr_o = r_fmt.rt;
    assign imm_sext  = {{16{i_fmt.imm[15]}}, i_fmt.imm};
    assign imm_zext  = {16'h0000, i_fmt.imm};

    // youngest producer first, r0 never forwarded
    assign ex_hit_rs  = ex_byp.wr_en && ex_byp.wr_addr == r_fmt.rs && r_fmt.rs != '0;
    assign ex_hit_rt  = ex_byp.wr_en && ex_byp.wr_addr == r_fmt.rt && r_fmt.rt != '0;
    assign mem_hit_rs = mem_byp.wr_en && mem_byp.wr_addr == r_fmt.rs && r_fmt.rs != '0;
    assign mem_hit_rt = mem_byp.wr_en && mem_byp.wr_addr == r_fmt.rt && r_fmt.rt != '0;

    assign rs_val = ex_hit_rs ? ex_byp.wr_data : (mem_hit_rs ? mem_byp.wr_data : rs_data_i);
    assign rt_val = ex_hit_rt ? ex_byp.wr_data : (mem_hit_rt ? mem_byp.wr_data : rt_data_i);

    // load still in execute, its data arrives one cycle later
    assign stall_o = ex_byp.is_load && ((ex_hit_rs && uses_rs) || (ex_hit_rt && uses_rt));

    always_comb begin
        dec         = '0;
        uses_rs     = 1'b0;
        uses_rt     = 1'b0;
        dec.alu_op  = alu_add;
        dec.op_a    = rs_val;
        dec.op_b    = imm_sext;
        dec.st_data = rt_val;
        dec.wr_addr = i_fmt.rt;
        case (r_fmt.opcode)
            op_special: begin
                dec.op_b    = rt_val;
                dec.wr_addr = r_fmt.rd;
                dec.wr_en   = 1'b1;
                uses_rs     = 1'b1;
                uses_rt     = 1'b1;
                case (r_fmt.funct)
                    fn_addu: dec.alu_op = alu_add;
                    fn_subu: dec.alu_op = alu_sub;
                    fn_and:  dec.alu_op = alu_and;
                    fn_or:   dec.alu_op = alu_or;
                    fn_xor:  dec.alu_op = alu_xor;
                    fn_nor:  dec.alu_op = alu_nor;
                    fn_slt:  dec.alu_op = alu_slt;
                    fn_sltu: dec.alu_op = alu_sltu;
                    default: begin
                        // unknown function, treated as a no-op
                        dec.wr_en = 1'b0;
                        uses_rs   = 1'b0;
                        uses_rt   = 1'b0;
                    end
                endcase
            end
            op_addiu: begin
                dec.wr_en = 1'b1;
                uses_rs   = 1'b1;
            end
            op_andi, op_ori, op_xori: begin
                dec.op_b   = imm_zext;
                dec.wr_en  = 1'b1;
                uses_rs    = 1'b1;
                dec.alu_op = (r_fmt.opcode == op_andi) ? alu_and :
                             (r_fmt.opcode == op_ori)  ? alu_or  : alu_xor;
            end
            op_lui: begin
                dec.alu_op = alu_lui;
                dec.op_b   = imm_zext;
                dec.wr_en  = 1'b1;
            end
            op_lw: begin
                dec.wr_en   = 1'b1;
                dec.is_load = 1'b1;
                uses_rs     = 1'b1;
            end
            op_sw: begin
                dec.is_store = 1'b1;
                uses_rs      = 1'b1;
                uses_rt      = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o <= '0;
        end else if (stall_o) begin
            // bubble while the consumer waits in decode
            id_ex_o <= '0;
        end else begin
            id_ex_o <= dec;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/execute.sv ====
/* execute stage
   alu, load/store address and execute/memory register */
`timescale 1ns/1ps
`default_nettype none

module execute import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  id_ex_t    id_ex_i,
    bypass_if.source  ex_byp,
    output ex_mem_t   ex_mem_o
);

    word_t op_a;
    word_t op_b;
    word_t result;

    assign op_a = id_ex_i.op_a;
    assign op_b = id_ex_i.op_b;

    // loads and stores come in as alu_add, base plus offset
    always_comb begin
        case (id_ex_i.alu_op)
            alu_add:  result = op_a + op_b;
            alu_sub:  result = op_a - op_b;
            alu_and:  result = op_a & op_b;
            alu_or:   result = op_a | op_b;
            alu_xor:  result = op_a ^ op_b;
            alu_nor:  result = ~(op_a | op_b);
            alu_slt:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: result = {31'b0, op_a < op_b};
            alu_lui:  result = {op_b[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    assign ex_byp.wr_en   = id_ex_i.wr_en;
    assign ex_byp.wr_addr = id_ex_i.wr_addr;
    assign ex_byp.wr_data = result;
    assign ex_byp.is_load = id_ex_i.is_load;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o.result   <= result;
            ex_mem_o.st_data  <= id_ex_i.st_data;
            ex_mem_o.wr_addr  <= id_ex_i.wr_addr;
            ex_mem_o.wr_en    <= id_ex_i.wr_en;
            ex_mem_o.is_load  <= id_ex_i.is_load;
            ex_mem_o.is_store <= id_ex_i.is_store;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_access.sv ====
/* memory stage
   data ram access and memory/write-back register */
`timescale 1ns/1ps
`default_nettype none

module mem_access import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  ex_mem_t   ex_mem_i,
    input  word_t     ram_data_i,
    bypass_if.source  mem_byp,
    output logic      ram_en_o,
    output logic      ram_wr_en_o,
    output word_t     ram_addr_o,
    output word_t     ram_data_o,
    output wb_t       wb_o
);

    word_t wb_data;

    // word accesses only, ram answers in the same cycle
    assign ram_en_o    = ex_mem_i.is_load || ex_mem_i.is_store;
    assign ram_wr_en_o = ex_mem_i.is_store;
    assign ram_addr_o  = ex_mem_i.result;
    assign ram_data_o  = ex_mem_i.st_data;

    assign wb_data = ex_mem_i.is_load ? ram_data_i : ex_mem_i.result;

    // load data is already here, so no stall from this stage
    assign mem_byp.wr_en   = ex_mem_i.wr_en;
    assign mem_byp.wr_addr = ex_mem_i.wr_addr;
    assign mem_byp.wr_data = wb_data;
    assign mem_byp.is_load = 1'b0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_o <= '0;
        end else begin
            wb_o.wr_en   <= ex_mem_i.wr_en;
            wb_o.wr_addr <= ex_mem_i.wr_addr;
            wb_o.wr_data <= wb_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mips_cpu.sv ====
/* mips32 five-stage integer core
   fetch, decode, execute, memory and write-back with rom and ram ports */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu import mips_isa_pkg::*, mips_pipe_pkg::*; (
    input  logic  clk,
    input  logic  arst_n_i,
    input  word_t rom_data_i,
    output word_t rom_addr_o,
    output logic  rom_en_o,
    input  word_t ram_data_i,
    output logic  ram_en_o,
    output logic  ram_wr_en_o,
    output word_t ram_addr_o,
    output word_t ram_data_o
);

    logic      stall;
    word_t     instr;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    wb_t       wb;

    // forwarding from execute and memory back to decode
    bypass_if ex_byp ();
    bypass_if mem_byp ();

    fetch u_fetch (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall),
        .rom_data_i (rom_data_i),
        .rom_addr_o (rom_addr_o),
        .rom_en_o   (rom_en_o),
        .instr_o    (instr)
    );

    regfile u_regfile (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .wb_i      (wb),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data)
    );

    decode u_decode (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .instr_i   (instr),
        .rs_data_i (rs_data),
        .rt_data_i (rt_data),
        .ex_byp    (ex_byp.sink),
        .mem_byp   (mem_byp.sink),
        .rs_addr_o (rs_addr),
        .rt_addr_o (rt_addr),
        .stall_o   (stall),
        .id_ex_o   (id_ex)
    );

    execute u_execute (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .id_ex_i  (id_ex),
        .ex_byp   (ex_byp.source),
        .ex_mem_o (ex_mem)
    );

    mem_access u_mem_access (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .ex_mem_i    (ex_mem),
        .ram_data_i  (ram_data_i),
        .mem_byp     (mem_byp.source),
        .ram_en_o    (ram_en_o),
        .ram_wr_en_o (ram_wr_en_o),
        .ram_addr_o  (ram_addr_o),
        .ram_data_o  (ram_data_o),
        .wb_o        (wb)
    );

endmodule

`default_nettype wire

// ==== bench/mips_cpu_sva.sv ====
/* port assertions for the mips core
   ram strobes around reset, write implies enable, aligned ram, steady fetch */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_sva import mips_isa_pkg::*; (
    input logic  clk,
    input logic  arst_n_i,
    input logic  rom_en_i,
    input logic  ram_en_i,
    input logic  ram_wr_en_i,
    input word_t ram_addr_i
);

    int unsigned fail_reset = 0;
    int unsigned fail_wr = 0;
    int unsigned fail_align = 0;
    int unsigned fail_rom = 0;

    // nothing reaches the memory stage this early
    // the sample two edges after release covers the first clocked cycle
    ram_quiet_a: assert property (@(posedge clk)
        (!arst_n_i || !$past(arst_n_i, 2)) |-> (!ram_en_i && !ram_wr_en_i))
        else begin
            fail_reset++;
            $error("ram strobe active in reset or in the first cycle after it");
        end

    wr_has_en_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        ram_wr_en_i |-> ram_en_i)
        else begin
            fail_wr++;
            $error("ram write without ram enable");
        end

    // word accesses only
    ram_align_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        ram_en_i |-> (ram_addr_i[1:0] == 2'b00))
        else begin
            fail_align++;
            $error("ram address not word aligned");
        end

    rom_steady_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        rom_en_i |=> rom_en_i)
        else begin
            fail_rom++;
            $error("rom enable dropped after reset");
        end

endmodule

bind mips_cpu mips_cpu_sva u_sva (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .rom_en_i    (rom_en_o),
    .ram_en_i    (ram_en_o),
    .ram_wr_en_i (ram_wr_en_o),
    .ram_addr_i  (ram_addr_o)
);

`default_nettype wire

// ==== bench/mips_cpu_tb.sv ====
/* mips core testbench
   runs alu, immediate, forwarding and load-use cases and checks every store */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_tb import mips_isa_pkg::*, mips_pipe_pkg::*; ();

    localparam int rom_words = 1024;
    localparam int ram_words = 1024;
    localparam int store_timeout = 100;
    localparam int n_directed = 19;
    localparam int n_random = 8;

    // first eight kinds line up with the r-type cycle of the random cases
    typedef enum logic [4:0] {
        k_addu, k_subu, k_and, k_or, k_xor, k_nor, k_slt, k_sltu,
        k_addiu, k_andi, k_ori, k_xori, k_lui,
        k_dep1, k_dep2, k_dep3, k_lduse, k_zero
    } test_kind_e;

    typedef struct packed {
        test_kind_e kind;
        word_t      a;
        word_t      b;
        word_t      exp;
    } test_t;

    localparam reg_addr_t r0 = 5'd0;
    localparam reg_addr_t r1 = 5'd1;
    localparam reg_addr_t r2 = 5'd2;
    localparam reg_addr_t r3 = 5'd3;
    localparam reg_addr_t r4 = 5'd4;
    localparam reg_addr_t r5 = 5'd5;
    localparam reg_addr_t r6 = 5'd6;

    // operation, operand a, operand b, expected stored word
    localparam test_t directed_tbl [n_directed] = '{
        '{k_addu,  32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000},
        '{k_subu,  32'h0000_0005, 32'h0000_0007, 32'hffff_fffe},
        '{k_and,   32'hf0f0_1234, 32'h0ff0_ff00, 32'h00f0_1200},
        '{k_or,    32'hf000_000f, 32'h0f00_00f0, 32'hff00_00ff},
        '{k_xor,   32'haaaa_5555, 32'hffff_0000, 32'h5555_5555},
        '{k_nor,   32'h1234_0000, 32'h0000_5678, 32'hedcb_a987},
        '{k_slt,   32'hffff_fff0, 32'h0000_0001, 32'h0000_0001},
        '{k_slt,   32'h8000_0000, 32'h7fff_ffff, 32'h0000_0001},
        '{k_sltu,  32'hffff_fff0, 32'h0000_0001, 32'h0000_0000},
        '{k_addiu, 32'h0000_0100, 32'h0000_fff0, 32'h0000_00f0},
        '{k_andi,  32'hffff_ffff, 32'h0000_8001, 32'h0000_8001},
        '{k_ori,   32'h1234_0000, 32'h0000_8000, 32'h1234_8000},
        '{k_xori,  32'hffff_0000, 32'h0000_ffff, 32'hffff_ffff},
        '{k_lui,   32'h0000_0000, 32'h0000_abcd, 32'habcd_0000},
        '{k_dep1,  32'h1000_0001, 32'h0000_00ff, 32'h0000_0101},
        '{k_dep2,  32'h0000_00ff, 32'h0000_0f0f, 32'h0000_1001},
        '{k_dep3,  32'h0000_ff00, 32'h0000_0ff0, 32'h0000_0f00},
        '{k_lduse, 32'h1357_9bdf, 32'h0000_0001, 32'h1357_9be0},
        '{k_zero,  32'h0000_0007, 32'h0000_ffff, 32'h0000_0000}
    };

    logic  clk = 1'b0;
    logic  arst_n = 1'b0;
    word_t rom_data = '0;
    word_t rom_addr;
    logic  rom_en;
    word_t ram_rdata = '0;
    logic  ram_en;
    logic  ram_wr_en;
    word_t ram_addr;
    word_t ram_wdata;

    word_t       rom [rom_words];
    word_t       ram [ram_words];
    logic        st_pend = 1'b0;
    word_t       st_addr;
    word_t       st_data;
    word_t       exp_addr_q [$];
    word_t       exp_data_q [$];
    word_t       seen_addr_q [$];
    word_t       seen_data_q [$];
    int          pc_idx;
    int          mismatches;
    int          timeouts;
    logic [31:0] lfsr = 32'd69;

    mips_cpu u_dut (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .rom_data_i  (rom_data),
        .rom_addr_o  (rom_addr),
        .rom_en_o    (rom_en),
        .ram_data_i  (ram_rdata),
        .ram_en_o    (ram_en),
        .ram_wr_en_o (ram_wr_en),
        .ram_addr_o  (ram_addr),
        .ram_data_o  (ram_wdata)
    );

    always #10 clk = ~clk;

    // memory read data and store capture settle mid-cycle
    always @(negedge clk) begin
        rom_data  <= (rom_addr < 4 * rom_words) ? rom[rom_addr[11:2]] : nop_instr;
        ram_rdata <= ram[ram_addr[11:2]];
        st_pend   <= arst_n && ram_en && ram_wr_en;
        st_addr   <= ram_addr;
        st_data   <= ram_wdata;
        if (arst_n && ram_en && ram_wr_en) begin
            seen_addr_q.push_back(ram_addr);
            seen_data_q.push_back(ram_wdata);
        end
    end

    always @(posedge clk) begin
        if (st_pend) begin
            ram[st_addr[11:2]] = st_data;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_word(output word_t w);
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    // mips semantics of the register-register operations
    function automatic word_t ref_rtype(input test_kind_e kind, input word_t a, input word_t b);
        word_t r;
        case (kind)
            k_addu:  r = a + b;
            k_subu:  r = a - b;
            k_and:   r = a & b;
            k_or:    r = a | b;
            k_xor:   r = a ^ b;
            k_nor:   r = ~(a | b);
            k_slt:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            k_sltu:  r = (a < b) ? 32'd1 : 32'd0;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic word_t enc_r(input funct_e fn, input reg_addr_t rs, input reg_addr_t rt,
                                    input reg_addr_t rd);
        return {op_special, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t enc_i(input opcode_e op, input reg_addr_t rs, input reg_addr_t rt,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic put(input word_t instr);
        rom[pc_idx] = instr;
        pc_idx++;
    endtask

    // operands go to r1 and r2 and the r3 result is stored at four times the index
    task automatic add_case(input int idx, input test_t t);
        word_t     scratch;
        reg_addr_t src;
        scratch = word_t'(32'h200 + 4 * idx);
        src     = r3;
        put(enc_i(op_lui, r0, r1, t.a[31:16]));
        put(enc_i(op_ori, r1, r1, t.a[15:0]));
        put(enc_i(op_lui, r0, r2, t.b[31:16]));
        put(enc_i(op_ori, r2, r2, t.b[15:0]));
        case (t.kind)
            k_addu:  put(enc_r(fn_addu, r1, r2, r3));
            k_subu:  put(enc_r(fn_subu, r1, r2, r3));
            k_and:   put(enc_r(fn_and, r1, r2, r3));
            k_or:    put(enc_r(fn_or, r1, r2, r3));
            k_xor:   put(enc_r(fn_xor, r1, r2, r3));
            k_nor:   put(enc_r(fn_nor, r1, r2, r3));
            k_slt:   put(enc_r(fn_slt, r1, r2, r3));
            k_sltu:  put(enc_r(fn_sltu, r1, r2, r3));
            k_addiu: put(enc_i(op_addiu, r1, r3, t.b[15:0]));
            k_andi:  put(enc_i(op_andi, r1, r3, t.b[15:0]));
            k_ori:   put(enc_i(op_ori, r1, r3, t.b[15:0]));
            k_xori:  put(enc_i(op_xori, r1, r3, t.b[15:0]));
            k_lui:   put(enc_i(op_lui, r0, r3, t.b[15:0]));
            k_dep1: begin
                put(enc_r(fn_addu, r1, r2, r4));
                put(enc_r(fn_xor, r4, r1, r3));
            end
            k_dep2: begin
                put(enc_r(fn_addu, r1, r2, r4));
                put(enc_r(fn_and, r1, r2, r5));
                put(enc_r(fn_xor, r4, r5, r3));
            end
            k_dep3: begin
                put(enc_r(fn_addu, r1, r2, r4));
                put(enc_r(fn_and, r1, r2, r5));
                put(enc_r(fn_or, r1, r2, r6));
                put(enc_r(fn_subu, r4, r6, r3));
            end
            k_lduse: begin
                // park a in memory and reload it for immediate use
                put(enc_i(op_sw, r0, r1, scratch[15:0]));
                put(enc_i(op_lw, r0, r4, scratch[15:0]));
                put(enc_r(fn_addu, r4, r2, r3));
                exp_addr_q.push_back(scratch);
                exp_data_q.push_back(t.a);
            end
            k_zero: begin
                put(enc_r(fn_addu, r1, r2, r0));
                put(enc_i(op_lui, r0, r0, t.b[15:0]));
                src = r0;
            end
            default: begin
            end
        endcase
        put(enc_i(op_sw, r0, src, 16'(4 * idx)));
        exp_addr_q.push_back(word_t'(4 * idx));
        exp_data_q.push_back(t.exp);
    endtask

    task automatic check_addr(input int k, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: ram_addr_o of store %0d is %h, expected %h",
                     $time, k, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_word(input int k, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: ram_data_o of store %0d is %h, expected %h",
                     $time, k, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s is %b, expected %b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    initial begin
        test_t       t;
        int          wait_cnt;
        int unsigned sva_fails;
        mismatches = 0;
        timeouts   = 0;
        pc_idx     = 0;
        for (int i = 0; i < rom_words; i++) begin
            rom[i] = nop_instr;
        end
        for (int i = 0; i < ram_words; i++) begin
            ram[i] = word_t'(i * 4) ^ 32'hc3c3_5a5a;
        end
        for (int i = 0; i < n_directed; i++) begin
            add_case(i, directed_tbl[i]);
        end
        for (int j = 0; j < n_random; j++) begin
            t.kind = test_kind_e'(j % 8);
            rand_word(t.a);
            rand_word(t.b);
            t.exp = ref_rtype(t.kind, t.a, t.b);
            add_case(n_directed + j, t);
        end

        repeat (8) @(negedge clk);
        check_flag("rom_en_o", rom_en, 1'b0);
        arst_n = 1'b1;
        // fetch is enabled from the first edge after release
        @(negedge clk);
        check_flag("rom_en_o", rom_en, 1'b1);

        for (int k = 0; k < exp_addr_q.size() && timeouts == 0; k++) begin
            wait_cnt = 0;
            while (seen_addr_q.size() == 0 && wait_cnt < store_timeout) begin
                @(posedge clk);
                wait_cnt++;
            end
            if (seen_addr_q.size() == 0) begin
                $display("timeout: store %0d never appeared on the ram port", k);
                timeouts++;
            end else begin
                check_addr(k, seen_addr_q.pop_front(), exp_addr_q[k]);
                check_word(k, seen_data_q.pop_front(), exp_data_q[k]);
            end
        end
        if (seen_addr_q.size() != 0) begin
            $display("error: %0d stores appeared beyond the program", seen_addr_q.size());
            mismatches++;
        end

        sva_fails = u_dut.u_sva.fail_reset + u_dut.u_sva.fail_wr +
                    u_dut.u_sva.fail_align + u_dut.u_sva.fail_rom;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, sva_fails);
        if (mismatches == 0 && timeouts == 0 && sva_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verilog
verilog/mips_isa_pkg.sv
verilog/mips_pipe_pkg.sv
verilog/bypass_if.sv
verilog/fetch.sv
verilog/regfile.sv
verilog/decode.sv
verilog/execute.sv
verilog/mem_access.sv
verilog/mips_cpu.sv
bench/mips_cpu_sva.sv
bench/mips_cpu_tb.sv

// ==== Makefile ====
# Verilator build and run for the mips core testbench

VERILATOR ?= verilator
TOP       ?= mips_cpu_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
